/* list.f */
+incdir+logic
logic/alu_pkg.sv
logic/fifo_if.sv
logic/fifo_buffer.sv
logic/cmd_receiver.sv
logic/alu_core.sv
logic/alu_exec.sv
logic/res_sender.sv
logic/alu_unit_top.sv
test/alu_unit_chk.sv
test/alu_unit_tb.sv

/* logic/alu_core.sv */
//--------------------------------------------------------------------------
// combinational ALU producing the result value and the c, z, n, v flags
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

module alu_core (
  input  alu_pkg::alu_op_t      op,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic                  c_in,
  input  logic                  z_prev,
  output alu_pkg::alu_res_t     res
);
  import alu_pkg::*;

  localparam int W = `ALU_WIDTH;
  localparam int M = W - 1;

  logic [W:0]        add_wide;
  logic [W-1:0]      diff;
  logic [W:0]        shl_wide;
  logic [W:0]        shr_wide;
  logic signed [W:0] sar_wide;
  logic [W-1:0]      mul_s;
  logic [W-1:0]      mul_u;
  logic [W-1:0]      value;
  logic              c;
  logic              v;

  assign add_wide = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, c_in};
  assign diff     = a - b;

  // one spare bit on each shift catches the last bit shifted out,
  // so an amount of 0 leaves it clear and large amounts behave naturally
  assign shl_wide = {1'b0, a} << b;
  assign shr_wide = {a, 1'b0} >> b;
  assign sar_wide = $signed({a, 1'b0}) >>> b;

  assign mul_s = $signed(a) * $signed(b); // low half only
  assign mul_u = a * b;

  always_comb begin
    value = a;
    c     = c_in;
    v     = 1'b0;
    case (op)
      ALU_AND: value = a & b;
      ALU_OR:  value = a | b;
      ALU_XOR: value = a ^ b;
      ALU_ADD: begin
        value = add_wide[M:0];
        c     = add_wide[W];
        v     = (a[M] == b[M]) & (value[M] != a[M]);
      end
      ALU_SUB: begin
        value = diff;
        c     = (a < b); // borrow
        v     = (a[M] != b[M]) & (value[M] != a[M]);
      end
      ALU_SHL: begin
        value = shl_wide[M:0];
        c     = shl_wide[W];
        v     = value[M] ^ c;
      end
      ALU_SHR: begin
        value = shr_wide[W:1];
        c     = shr_wide[0];
        v     = value[M] ^ c;
      end
      ALU_SAR: begin
        value = sar_wide[W:1];
        c     = sar_wide[0];
        v     = value[M] ^ c;
      end
      ALU_MUL: begin
        value = mul_s;
        c     = 1'b0;
      end
      ALU_MULU: begin
        value = mul_u;
        c     = 1'b0;
      end
      default: ; // codes 10 to 15 pass a through
    endcase
  end

  assign res.value   = value;
  assign res.flags.c = c;
  assign res.flags.z = ~|value & z_prev; // chained zero needs the previous zero too
  assign res.flags.n = value[M];
  assign res.flags.v = v;

endmodule

`default_nettype wire

/* logic/alu_defines.svh */
//--------------------------------------------------------------------------
// data width and queue depth macros for the ALU execution unit
//--------------------------------------------------------------------------
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// width of operands and results
`define ALU_WIDTH 32

// entries in the command and result queues
`define CMD_FIFO_DEPTH 4
`define RES_FIFO_DEPTH 4

`endif

/* logic/alu_exec.sv */
//--------------------------------------------------------------------------
// execute stage with the flag register between the two FIFOs
//--------------------------------------------------------------------------
`default_nettype none

module alu_exec (
  input logic    clk,
  input logic    arst_n,
  fifo_if.reader cq,
  fifo_if.writer rq
);
  import alu_pkg::*;

  alu_cmd_t   cmd;
  alu_res_t   res;
  alu_flags_t flags_q;
  logic       go;
  logic       c_in;
  logic       z_prev;

  assign cmd = cq.rd_data;

  // one command per cycle while there is input and room for the result
  assign go = ~cq.empty & ~rq.full;

  assign c_in   = cmd.chain & flags_q.c;
  assign z_prev = ~cmd.chain | flags_q.z;

  alu_core i_core (
    .op     (cmd.op),
    .a      (cmd.a),
    .b      (cmd.b),
    .c_in   (c_in),
    .z_prev (z_prev),
    .res    (res)
  );

  assign cq.pop     = go;
  assign rq.push    = go;
  assign rq.wr_data = res;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags_q <= '0;
    end else if (go) begin
      flags_q <= res.flags; // flags of the command just executed
    end
  end

endmodule

`default_nettype wire

/* logic/alu_pkg.sv */
//--------------------------------------------------------------------------
// opcode, flag, command and result types of the ALU execution unit
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

package alu_pkg;

  // codes 10 to 15 are legal and pass operand a through
  typedef enum logic [3:0] {
    ALU_AND  = 4'd0,
    ALU_OR   = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_SHL  = 4'd4,
    ALU_SAR  = 4'd5,
    ALU_SHR  = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_MUL  = 4'd8,
    ALU_MULU = 4'd9
  } alu_op_t;

  typedef struct packed {
    logic c;
    logic z;
    logic n;
    logic v;
  } alu_flags_t;

  typedef struct packed {
    alu_op_t               op;
    logic                  chain; // take carry and zero from the previous command
    logic [`ALU_WIDTH-1:0] a;
    logic [`ALU_WIDTH-1:0] b;
  } alu_cmd_t;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0] value;
    alu_flags_t            flags;
  } alu_res_t;

endpackage

`default_nettype wire

/* logic/alu_unit_top.sv */
//--------------------------------------------------------------------------
// ALU execution unit top with ports, queues and execute stage
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

module alu_unit_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cmd_req,
  output logic                  cmd_ack,
  input  logic [3:0]            cmd_op,
  input  logic                  cmd_chain,
  input  logic [`ALU_WIDTH-1:0] cmd_a,
  input  logic [`ALU_WIDTH-1:0] cmd_b,
  output logic                  res_req,
  input  logic                  res_ack,
  output logic [`ALU_WIDTH-1:0] res_value,
  output logic                  res_c,
  output logic                  res_z,
  output logic                  res_n,
  output logic                  res_v
);
  import alu_pkg::*;

  fifo_if #(.T(alu_cmd_t)) cmd_q ();
  fifo_if #(.T(alu_res_t)) res_q ();

  cmd_receiver i_receiver (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .cmd_op    (cmd_op),
    .cmd_chain (cmd_chain),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .q         (cmd_q)
  );

  fifo_buffer #(.T(alu_cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) i_cmd_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .q      (cmd_q)
  );

  alu_exec i_exec (
    .clk    (clk),
    .arst_n (arst_n),
    .cq     (cmd_q),
    .rq     (res_q)
  );

  fifo_buffer #(.T(alu_res_t), .DEPTH(`RES_FIFO_DEPTH)) i_res_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .q      (res_q)
  );

  // a slow host ack backs up through both queues to the command port
  res_sender i_sender (
    .clk       (clk),
    .arst_n    (arst_n),
    .q         (res_q),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .res_value (res_value),
    .res_c     (res_c),
    .res_z     (res_z),
    .res_n     (res_n),
    .res_v     (res_v)
  );

endmodule

`default_nettype wire

/* logic/cmd_receiver.sv */
//--------------------------------------------------------------------------
// four-phase host command port feeding the command FIFO
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

module cmd_receiver (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cmd_req,
  output logic                  cmd_ack,
  input  logic [3:0]            cmd_op,
  input  logic                  cmd_chain,
  input  logic [`ALU_WIDTH-1:0] cmd_a,
  input  logic [`ALU_WIDTH-1:0] cmd_b,
  fifo_if.writer                q
);
  import alu_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_ACK
  } state_t;

  state_t   state;
  alu_cmd_t cmd_word;
  logic     take;

  // a full queue holds off the ack, so the host simply waits
  assign take = (state == S_IDLE) & cmd_req & ~q.full;

  always_comb begin
    cmd_word.op    = alu_op_t'(cmd_op);
    cmd_word.chain = cmd_chain;
    cmd_word.a     = cmd_a;
    cmd_word.b     = cmd_b;
  end

  assign q.push    = take;
  assign q.wr_data = cmd_word;
  assign cmd_ack   = (state == S_ACK);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (take) state <= S_ACK;
        S_ACK:  if (!cmd_req) state <= S_IDLE; // host has seen the ack
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/fifo_buffer.sv */
//--------------------------------------------------------------------------
// show-ahead synchronous FIFO, payload type and depth set by parameters
//--------------------------------------------------------------------------
`default_nettype none

module fifo_buffer #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input logic    clk,
  input logic    arst_n,
  fifo_if.buffer q
);

  localparam int              AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW-1:0]   LAST     = AW'(DEPTH - 1);
  localparam logic [AW:0]     FULL_CNT = (AW + 1)'(DEPTH);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign do_push = q.push & ~q.full;
  assign do_pop  = q.pop & ~q.empty;

  assign q.full    = (count == FULL_CNT);
  assign q.empty   = (count == '0);
  assign q.rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.wr_data;
    end
  end

  // pointers wrap at DEPTH so any depth works, not only powers of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // push with pop keeps the level
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/fifo_if.sv */
//--------------------------------------------------------------------------
// FIFO interface with writer, reader and buffer views
//--------------------------------------------------------------------------
`default_nettype none

interface fifo_if #(
  parameter type T = logic
);
  logic push;
  logic full;
  T     wr_data;
  logic pop;
  logic empty;
  T     rd_data; // head entry, valid while empty is low

  modport writer (output push, output wr_data, input full);

  modport reader (output pop, input empty, input rd_data);

  modport buffer (
    input  push,
    input  wr_data,
    input  pop,
    output full,
    output empty,
    output rd_data
  );
endinterface

`default_nettype wire

/* logic/res_sender.sv */
//--------------------------------------------------------------------------
// four-phase result port draining the result FIFO to the host
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

module res_sender (
  input  logic                  clk,
  input  logic                  arst_n,
  fifo_if.reader                q,
  output logic                  res_req,
  input  logic                  res_ack,
  output logic [`ALU_WIDTH-1:0] res_value,
  output logic                  res_c,
  output logic                  res_z,
  output logic                  res_n,
  output logic                  res_v
);
  import alu_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_REQ
  } state_t;

  state_t   state;
  alu_res_t out_q;
  logic     load;

  // wait for the previous ack to drop before offering the next result
  assign load   = (state == S_IDLE) & ~res_ack & ~q.empty;
  assign q.pop  = load;

  always_ff @(posedge clk) begin
    if (load) begin
      out_q <= q.rd_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (load) state <= S_REQ;
        S_REQ:   if (res_ack) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  assign res_req   = (state == S_REQ);
  assign res_value = out_q.value;
  assign res_c     = out_q.flags.c;
  assign res_z     = out_q.flags.z;
  assign res_n     = out_q.flags.n;
  assign res_v     = out_q.flags.v;

endmodule

`default_nettype wire

/* test/alu_unit_chk.sv */
//--------------------------------------------------------------------------
// concurrent assertions on the host command and result handshakes
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

module alu_unit_chk (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  cmd_req,
  input logic                  cmd_ack,
  input logic                  cmd_full,
  input logic                  res_req,
  input logic                  res_ack,
  input logic [`ALU_WIDTH-1:0] res_value,
  input logic                  res_c,
  input logic                  res_z,
  input logic                  res_n,
  input logic                  res_v
);
  timeunit 1ns;
  timeprecision 100ps;

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cmd_ack) |-> $past(cmd_req))
    else $error("cmd_ack rose without a pending cmd_req");

  // a full command queue holds the ack off
  a_ack_waits_full: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_req && !cmd_ack && cmd_full |=> !cmd_ack)
    else $error("cmd_ack rose while the command queue was full");

  a_res_stable: assert property (@(posedge clk) disable iff (!arst_n)
    res_req && !res_ack |=> $stable({res_value, res_c, res_z, res_n, res_v}))
    else $error("result outputs changed while res_req waited for res_ack");

  a_req_holds: assert property (@(posedge clk) disable iff (!arst_n)
    res_req && !res_ack |=> res_req)
    else $error("res_req dropped before res_ack");

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !cmd_ack && !res_req)
    else $error("cmd_ack or res_req high during reset");

endmodule

`default_nettype wire

/* test/alu_unit_tb.sv */
//--------------------------------------------------------------------------
// testbench with clock, reset, random host driver, result acceptor and model
//--------------------------------------------------------------------------
`default_nettype none
`include "alu_defines.svh"

module alu_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import alu_pkg::*;

  localparam int W         = `ALU_WIDTH;
  localparam int SEED      = 77;
  localparam int N_PHASES  = 6;
  localparam int PHASE_LEN = 60;
  localparam int N_CMDS    = N_PHASES * PHASE_LEN;
  localparam int ACK_MAX   = 6;
  localparam int HS_CYCLES = 4;
  localparam int CLK_NS    = 20;
  localparam int QUEUED    = `CMD_FIFO_DEPTH + `RES_FIFO_DEPTH;
  localparam int TIMEOUT_NS = (N_CMDS * (HS_CYCLES + ACK_MAX + QUEUED) + 20) * CLK_NS;
  localparam longint SMAX  = (longint'(1) <<< (W - 1)) - 1;
  localparam longint SMIN  = -SMAX - 1;

  logic         clk;
  logic         arst_n;
  logic         cmd_req;
  logic         cmd_ack;
  logic [3:0]   cmd_op;
  logic         cmd_chain;
  logic [W-1:0] cmd_a;
  logic [W-1:0] cmd_b;
  logic         res_req;
  logic         res_ack;
  logic [W-1:0] res_value;
  logic         res_c;
  logic         res_z;
  logic         res_n;
  logic         res_v;

  alu_res_t   exp_q[$];
  alu_flags_t mdl_flags; // flag register of the reference model
  logic       ack_slow;
  int         acked;
  int         received;
  int         max_inflight;

  alu_unit_top i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .cmd_op    (cmd_op),
    .cmd_chain (cmd_chain),
    .cmd_a     (cmd_a),
    .cmd_b     (cmd_b),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .res_value (res_value),
    .res_c     (res_c),
    .res_z     (res_z),
    .res_n     (res_n),
    .res_v     (res_v)
  );

  bind alu_unit_top alu_unit_chk i_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .cmd_full  (cmd_q.full),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .res_value (res_value),
    .res_c     (res_c),
    .res_z     (res_z),
    .res_n     (res_n),
    .res_v     (res_v)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_field(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] want);
    assert (got === want)
      else abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, want));
  endtask

  function automatic logic [W-1:0] pick_operand();
    case ($urandom_range(5))
      0: return '0;
      1: return '1;
      2: return {1'b1, {(W - 1){1'b0}}};
      default: return W'({$urandom(), $urandom()});
    endcase
  endfunction

  function automatic logic [W-1:0] pick_shift();
    case ($urandom_range(7))
      0: return '0;
      1: return W'(1);
      2: return W'(W - 1);
      3: return W'(W);
      4: return W'($urandom()); // mostly far beyond the width
      default: return W'($urandom_range(W + 2));
    endcase
  endfunction

  // phases 0 to 3 aim at one group of opcodes, 4 and 5 use all 16 codes
  function automatic logic [3:0] pick_op(input int phase);
    int r;
    case (phase)
      0: begin
        r = $urandom_range(8);
        return (r == 0) ? ALU_AND : (r == 1) ? ALU_OR : (r == 2) ? ALU_XOR : 4'(r + 7);
      end
      1: return $urandom_range(1) ? ALU_SUB : ALU_ADD;
      2: return 4'($urandom_range(6, 4));
      3: return $urandom_range(1) ? ALU_MULU : ALU_MUL;
      default: return 4'($urandom_range(15));
    endcase
  endfunction

  function automatic alu_res_t model_exec(input logic [3:0] op, input logic chain,
                                          input logic [W-1:0] a, input logic [W-1:0] b);
    alu_res_t            r;
    logic                cin;
    logic                zp;
    logic                big;
    int                  amt;
    longint              sa;
    longint              sb;
    longint              s;
    longint              u;
    logic [2*W-1:0]      pu;
    logic signed [W-1:0] a_s;
    cin = chain & mdl_flags.c;
    zp  = !chain | mdl_flags.z;
    sa  = $signed(a);
    sb  = $signed(b);
    a_s = a;
    r.value   = a;
    r.flags.c = cin;
    r.flags.v = 1'b0;
    case (op)
      ALU_AND: r.value = a & b;
      ALU_OR:  r.value = a | b;
      ALU_XOR: r.value = a ^ b;
      ALU_ADD: begin
        u = longint'(a) + longint'(b) + longint'(cin);
        s = sa + sb + longint'(cin);
        r.value   = u[W-1:0];
        r.flags.c = u[W];
        r.flags.v = (s > SMAX) || (s < SMIN);
      end
      ALU_SUB: begin
        s = sa - sb;
        r.value   = s[W-1:0];
        r.flags.c = (a < b);
        r.flags.v = (s > SMAX) || (s < SMIN);
      end
      ALU_SHL, ALU_SHR, ALU_SAR: begin
        big = (b >= W);
        amt = big ? W : int'(b);
        if (op == ALU_SHL) begin
          r.value   = big ? '0 : a << amt;
          r.flags.c = (amt == 0 || b > W) ? 1'b0 : a[W - amt];
        end else if (op == ALU_SHR) begin
          r.value   = big ? '0 : a >> amt;
          r.flags.c = (amt == 0 || b > W) ? 1'b0 : a[amt - 1];
        end else begin
          if (big) begin
            r.value = {W{a[W-1]}};
          end else begin
            r.value = a_s >>> amt;
          end
          r.flags.c = (amt == 0) ? 1'b0 : (big ? a[W-1] : a[amt - 1]);
        end
        r.flags.v = r.value[W-1] ^ r.flags.c;
      end
      ALU_MUL: begin
        s = sa * sb;
        r.value   = s[W-1:0];
        r.flags.c = 1'b0;
      end
      ALU_MULU: begin
        pu = a * b;
        r.value   = pu[W-1:0];
        r.flags.c = 1'b0;
      end
      default: ; // a passes through
    endcase
    r.flags.n = r.value[W-1];
    r.flags.z = (r.value == '0) && zp;
    mdl_flags = r.flags;
    return r;
  endfunction

  task automatic send_cmd(input logic [3:0] op, input logic chain,
                          input logic [W-1:0] a, input logic [W-1:0] b);
    exp_q.push_back(model_exec(op, chain, a, b));
    cmd_op    = op;
    cmd_chain = chain;
    cmd_a     = a;
    cmd_b     = b;
    cmd_req   = 1'b1;
    do begin
      @(posedge clk);
      #1;
      if (acked - received > max_inflight) begin
        max_inflight = acked - received;
      end
    end while (!cmd_ack);
    acked++;
    cmd_req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (cmd_ack);
  endtask

  task automatic run_commands();
    logic [3:0]   op;
    logic         chain;
    logic [W-1:0] a;
    logic [W-1:0] b;
    for (int p = 0; p < N_PHASES; p++) begin
      ack_slow     = (p == 4); // slow host backs up both queues
      max_inflight = 0;
      for (int i = 0; i < PHASE_LEN; i++) begin
        op    = pick_op(p);
        chain = (p == 1) ? ($urandom_range(3) != 0) : 1'($urandom_range(1));
        a     = pick_operand();
        b     = (op inside {ALU_SHL, ALU_SAR, ALU_SHR}) ? pick_shift() : pick_operand();
        if (p == 0 && i == 0) begin
          // all ones plus zero only wraps if a carry-in leaks out of reset
          op    = ALU_ADD;
          chain = 1'b0;
          a     = '1;
          b     = '0;
        end
        send_cmd(op, chain, a, b);
      end
      if (p == 4) begin
        assert (max_inflight >= QUEUED)
          else abort_run("back-pressure phase never filled both queues");
      end
    end
  endtask

  task automatic accept_results(input int total);
    alu_res_t exp;
    int       delay;
    for (int i = 0; i < total; i++) begin
      while (!res_req) begin
        @(posedge clk);
        #1;
      end
      assert (exp_q.size() > 0) else abort_run("result arrived with no command outstanding");
      exp = exp_q.pop_front();
      compare_field("res_value", res_value, exp.value);
      compare_field("res_c", res_c, exp.flags.c);
      compare_field("res_z", res_z, exp.flags.z);
      compare_field("res_n", res_n, exp.flags.n);
      compare_field("res_v", res_v, exp.flags.v);
      received++;
      delay = ack_slow ? ACK_MAX : $urandom_range(ACK_MAX);
      repeat (delay) @(posedge clk);
      if (delay > 0) begin
        #1;
      end
      res_ack = 1'b1;
      while (res_req) begin
        @(posedge clk);
        #1;
      end
      res_ack = 1'b0;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    abort_run($sformatf("run timed out with %0d of %0d results received", received, N_CMDS));
  end

  initial begin
    void'($urandom(SEED));
    arst_n       = 1'b1;
    cmd_req      = 1'b0;
    cmd_op       = '0;
    cmd_chain    = 1'b0;
    cmd_a        = '0;
    cmd_b        = '0;
    res_ack      = 1'b0;
    ack_slow     = 1'b0;
    acked        = 0;
    received     = 0;
    max_inflight = 0;
    mdl_flags    = '0;
    #2;
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    assert (!cmd_ack && !res_req) else abort_run("cmd_ack or res_req high after reset");
    fork
      run_commands();
      accept_results(N_CMDS);
    join
    // no further result may be offered once every command has been answered
    repeat (QUEUED) @(posedge clk);
    #1;
    if (exp_q.size() == 0 && !res_req) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("%0d results outstanding and res_req is %b after the last result",
                          exp_q.size(), res_req));
    end
  end

endmodule

`default_nettype wire
